//--- list.f
+incdir+rtl
rtl/music_box_pkg.sv
rtl/milli_timer.sv
rtl/tone_generator.sv
rtl/song_rom.sv
rtl/note_sequencer.sv
rtl/seg7_display.sv
rtl/music_box_top.sv
sim/tb_clock_gen.sv
sim/music_box_props.sv
sim/tb_music_box.sv

//--- rtl/milli_timer.sv
// millisecond strobe generator, restartable
`timescale 1ns/1ps
`include "music_box_cfg.svh"

module milli_timer (
  input  logic              clk,
  input  logic              rst,
  input  logic              restart,
  input  logic [`TPM_W-1:0] ticks_per_milli,
  output logic              ms_tick
);

  logic [`TPM_W-1:0] count;   // cycles into the current ms

  // strobe in the last cycle of each ms
  assign ms_tick = (count == ticks_per_milli - `TPM_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (restart || ms_tick) begin
      count <= '0;              // new ms starts next cycle
    end else begin
      count <= count + `TPM_W'(1);
    end
  end

endmodule

//--- rtl/music_box_cfg.svh
// widths, tempo, clock-rate factor and section lengths for the music box
`ifndef MUSIC_BOX_CFG_SVH
`define MUSIC_BOX_CFG_SVH

// datapath widths
`define PITCH_W 10      // pitch in Hz, 0 is silence
`define BEATS_W 4       // one rhythm entry
`define DUR_W 12        // note length in ms
`define TPM_W 16        // ticks_per_milli input
`define ACC_W 32        // tone accumulator

// tempo
`define BEAT_MS 100     // ms per beat

// song sections, trimmed tables
`define INTRO_LEN 13
`define VERSE_LEN 24
`define CHORUS_LEN 24

// part order
`define FIRST_PART 4    // chorus opens the song after reset
`define LAST_PART 6     // wraps back to part 1 after this

`endif

//--- rtl/music_box_pkg.sv
// shared music box types: pitch, beats, duration, part, note index, phase and note
`include "music_box_cfg.svh"

package music_box_pkg;

  // pitch in Hz, zero means a rest
  typedef logic [`PITCH_W-1:0] pitch_t;

  // note length in beats
  typedef logic [`BEATS_W-1:0] beats_t;

  // length in milliseconds
  typedef logic [`DUR_W-1:0] dur_t;

  typedef logic [2:0] part_t;       // 1 to 6
  typedef logic [4:0] note_idx_t;   // index within one section

  // sequencer phase
  typedef enum logic [1:0] {
    PH_LOAD,    // one cycle, fetch note
    PH_SOUND,   // note plays
    PH_GAP      // silence, a third of the note
  } phase_t;

  // one song table entry
  typedef struct packed {
    pitch_t pitch;
    beats_t beats;
  } note_t;

endpackage

//--- rtl/music_box_top.sv
// music box top level: timer, tone generator, song ROM, sequencer and display
`timescale 1ns/1ps
`include "music_box_cfg.svh"

module music_box_top (
  input  logic              clk,
  input  logic              rst,
  input  logic [`TPM_W-1:0] ticks_per_milli,
  output logic [7:0]        led,
  output logic              sound
);
  import music_box_pkg::*;

  logic      ms_tick;
  logic      ms_restart;
  part_t     part;
  note_idx_t note_idx;
  note_t     note;
  note_idx_t section_len;
  pitch_t    tone_pitch;
  phase_t    phase;

  milli_timer u_milli_timer (
    .clk             (clk),
    .rst             (rst),
    .restart         (ms_restart),
    .ticks_per_milli (ticks_per_milli),
    .ms_tick         (ms_tick)
  );

  tone_generator u_tone_generator (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .pitch           (tone_pitch),
    .sound           (sound)
  );

  song_rom u_song_rom (
    .part        (part),
    .note_idx    (note_idx),
    .note        (note),
    .section_len (section_len)
  );

  note_sequencer u_note_sequencer (
    .clk         (clk),
    .rst         (rst),
    .ms_tick     (ms_tick),
    .note        (note),
    .section_len (section_len),
    .ms_restart  (ms_restart),
    .part        (part),
    .note_idx    (note_idx),
    .tone_pitch  (tone_pitch),
    .phase       (phase)
  );

  seg7_display u_seg7_display (
    .part  (part),
    .phase (phase),
    .led   (led)
  );

endmodule

//--- rtl/note_sequencer.sv
// note sequencer: part and note counters, phase FSM, duration counting
`timescale 1ns/1ps
`include "music_box_cfg.svh"

module note_sequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ms_tick,
  input  music_box_pkg::note_t     note,
  input  music_box_pkg::note_idx_t section_len,
  output logic                     ms_restart,
  output music_box_pkg::part_t     part,
  output music_box_pkg::note_idx_t note_idx,
  output music_box_pkg::pitch_t    tone_pitch,
  output music_box_pkg::phase_t    phase
);
  import music_box_pkg::*;

  dur_t dur;          // length of the current note in ms
  dur_t ms_cnt;       // ms done in this phase
  dur_t gap_len;
  dur_t load_dur;
  logic is_verse;
  logic sound_done;
  logic gap_done;
  logic last_note;

  assign is_verse = (part == part_t'(3)) || (part == part_t'(5));

  // verse notes play at half tempo
  assign load_dur = is_verse ? dur_t'(note.beats) * dur_t'(2 * `BEAT_MS)
                             : dur_t'(note.beats) * dur_t'(`BEAT_MS);

  assign gap_len = dur / dur_t'(3);

  // ms_tick marks the last cycle of a ms
  assign sound_done = ms_tick && (ms_cnt == dur - dur_t'(1));
  assign gap_done   = (gap_len == '0) || (ms_tick && (ms_cnt == gap_len - dur_t'(1)));
  assign last_note  = (note_idx >= section_len - note_idx_t'(1));

  // timer realigns at every phase start
  assign ms_restart = (phase == PH_LOAD) || ((phase == PH_SOUND) && sound_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= PH_LOAD;
      part       <= part_t'(`FIRST_PART);
      note_idx   <= '0;
      tone_pitch <= '0;
      dur        <= '0;
      ms_cnt     <= '0;
    end else begin
      case (phase)
        PH_LOAD: begin
          dur        <= load_dur;
          tone_pitch <= note.pitch;       // 0 for a rest
          ms_cnt     <= '0;
          phase      <= PH_SOUND;
        end
        PH_SOUND: begin
          if (sound_done) begin
            tone_pitch <= '0;
            ms_cnt     <= '0;
            phase      <= PH_GAP;
          end else if (ms_tick) begin
            ms_cnt <= ms_cnt + dur_t'(1);
          end
        end
        PH_GAP: begin
          if (gap_done) begin
            phase <= PH_LOAD;
            if (last_note) begin
              note_idx <= '0;
              part     <= (part == part_t'(`LAST_PART)) ? part_t'(1) : part + part_t'(1);
            end else begin
              note_idx <= note_idx + note_idx_t'(1);
            end
          end else if (ms_tick) begin
            ms_cnt <= ms_cnt + dur_t'(1);
          end
        end
        default: phase <= PH_LOAD;
      endcase
    end
  end

endmodule

//--- rtl/seg7_display.sv
// seven-segment decoder for the part number, dot lit while a note sounds
`timescale 1ns/1ps

module seg7_display (
  input  music_box_pkg::part_t  part,
  input  music_box_pkg::phase_t phase,
  output logic [7:0]            led
);
  import music_box_pkg::*;

  logic [3:0] digit;

  assign digit = {1'b0, part};

  /*
    segment order, bit 0 on top, clockwise, bit 6 in the middle
  */
  always_comb begin
    case (digit)
      4'd0:    led[6:0] = 7'b0111111;
      4'd1:    led[6:0] = 7'b0000110;
      4'd2:    led[6:0] = 7'b1011011;
      4'd3:    led[6:0] = 7'b1001111;
      4'd4:    led[6:0] = 7'b1100110;
      4'd5:    led[6:0] = 7'b1101101;
      4'd6:    led[6:0] = 7'b1111100;
      4'd7:    led[6:0] = 7'b0000111;
      4'd8:    led[6:0] = 7'b1111111;
      4'd9:    led[6:0] = 7'b1100111;
      default: led[6:0] = 7'b0000000;   // blank
    endcase
  end

  assign led[7] = (phase == PH_SOUND);   // dot

endmodule

//--- rtl/song_rom.sv
// song tables: intro, verse and chorus notes plus section lengths
`timescale 1ns/1ps
`include "music_box_cfg.svh"

module song_rom (
  input  music_box_pkg::part_t     part,
  input  music_box_pkg::note_idx_t note_idx,
  output music_box_pkg::note_t     note,
  output music_box_pkg::note_idx_t section_len
);
  import music_box_pkg::*;

  note_t intro_note;
  note_t verse_note;
  note_t chorus_note;

  // parts 1 and 2
  always_comb begin
    case (note_idx)
      5'd0:    intro_note = '{10'd554, 4'd6};   // c5s
      5'd1:    intro_note = '{10'd622, 4'd10};  // e5f
      5'd2:    intro_note = '{10'd622, 4'd6};
      5'd3:    intro_note = '{10'd698, 4'd6};   // f5
      5'd4:    intro_note = '{10'd831, 4'd1};   // a5f
      5'd5:    intro_note = '{10'd740, 4'd1};   // f5s
      5'd6:    intro_note = '{10'd698, 4'd1};
      5'd7:    intro_note = '{10'd622, 4'd1};
      5'd8:    intro_note = '{10'd554, 4'd6};
      5'd9:    intro_note = '{10'd622, 4'd10};
      5'd10:   intro_note = '{10'd0, 4'd4};     // rest
      5'd11:   intro_note = '{10'd415, 4'd2};   // a4f
      5'd12:   intro_note = '{10'd415, 4'd10};
      default: intro_note = '{10'd0, 4'd1};
    endcase
  end

  // parts 3 and 5, beats are doubled by the sequencer
  always_comb begin
    case (note_idx)
      5'd0:    verse_note = '{10'd0, 4'd6};     // rest
      5'd1:    verse_note = '{10'd277, 4'd1};   // c4s
      5'd2:    verse_note = '{10'd277, 4'd1};
      5'd3:    verse_note = '{10'd277, 4'd1};
      5'd4:    verse_note = '{10'd277, 4'd1};
      5'd5:    verse_note = '{10'd311, 4'd2};   // e4f
      5'd6:    verse_note = '{10'd0, 4'd1};
      5'd7:    verse_note = '{10'd261, 4'd1};   // c4
      5'd8:    verse_note = '{10'd233, 4'd1};   // b3f
      5'd9:    verse_note = '{10'd208, 4'd5};   // a3f
      5'd10:   verse_note = '{10'd0, 4'd1};
      5'd11:   verse_note = '{10'd233, 4'd1};
      5'd12:   verse_note = '{10'd233, 4'd1};
      5'd13:   verse_note = '{10'd261, 4'd1};
      5'd14:   verse_note = '{10'd277, 4'd3};
      5'd15:   verse_note = '{10'd208, 4'd1};
      5'd16:   verse_note = '{10'd415, 4'd2};   // a4f
      5'd17:   verse_note = '{10'd415, 4'd1};
      5'd18:   verse_note = '{10'd311, 4'd5};
      5'd19:   verse_note = '{10'd0, 4'd1};
      5'd20:   verse_note = '{10'd233, 4'd1};
      5'd21:   verse_note = '{10'd233, 4'd1};
      5'd22:   verse_note = '{10'd261, 4'd1};
      5'd23:   verse_note = '{10'd277, 4'd1};
      default: verse_note = '{10'd0, 4'd1};
    endcase
  end

  // parts 4 and 6
  always_comb begin
    case (note_idx)
      5'd0:    chorus_note = '{10'd466, 4'd1};  // b4f
      5'd1:    chorus_note = '{10'd466, 4'd1};
      5'd2:    chorus_note = '{10'd415, 4'd1};  // a4f
      5'd3:    chorus_note = '{10'd415, 4'd1};
      5'd4:    chorus_note = '{10'd698, 4'd3};  // f5
      5'd5:    chorus_note = '{10'd698, 4'd3};
      5'd6:    chorus_note = '{10'd622, 4'd6};  // e5f
      5'd7:    chorus_note = '{10'd466, 4'd1};
      5'd8:    chorus_note = '{10'd466, 4'd1};
      5'd9:    chorus_note = '{10'd415, 4'd1};
      5'd10:   chorus_note = '{10'd415, 4'd1};
      5'd11:   chorus_note = '{10'd622, 4'd3};
      5'd12:   chorus_note = '{10'd622, 4'd3};
      5'd13:   chorus_note = '{10'd554, 4'd3};  // c5s
      5'd14:   chorus_note = '{10'd523, 4'd1};  // c5
      5'd15:   chorus_note = '{10'd466, 4'd2};
      5'd16:   chorus_note = '{10'd554, 4'd1};
      5'd17:   chorus_note = '{10'd554, 4'd1};
      5'd18:   chorus_note = '{10'd554, 4'd1};
      5'd19:   chorus_note = '{10'd554, 4'd1};
      5'd20:   chorus_note = '{10'd554, 4'd3};
      5'd21:   chorus_note = '{10'd622, 4'd3};
      5'd22:   chorus_note = '{10'd523, 4'd3};
      5'd23:   chorus_note = '{10'd466, 4'd1};
      default: chorus_note = '{10'd0, 4'd1};
    endcase
  end

  // section select by part
  always_comb begin
    case (part)
      3'd3, 3'd5: begin
        note        = verse_note;
        section_len = note_idx_t'(`VERSE_LEN);
      end
      3'd4, 3'd6: begin
        note        = chorus_note;
        section_len = note_idx_t'(`CHORUS_LEN);
      end
      default: begin              // parts 1, 2
        note        = intro_note;
        section_len = note_idx_t'(`INTRO_LEN);
      end
    endcase
  end

endmodule

//--- rtl/tone_generator.sv
// phase-accumulator square-wave generator
`timescale 1ns/1ps
`include "music_box_cfg.svh"

module tone_generator (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`TPM_W-1:0]     ticks_per_milli,
  input  music_box_pkg::pitch_t pitch,
  output logic                  sound
);

  logic [`ACC_W-1:0] acc;           // phase accumulator
  logic [`ACC_W-1:0] half_period;   // clock rate / 2, in ticks
  logic [`ACC_W-1:0] step;
  logic              wrap;

  // ticks per second is tpm * 1000, half of it is the toggle threshold
  assign half_period = `ACC_W'(ticks_per_milli) * `ACC_W'(500);
  assign step        = `ACC_W'(pitch);
  assign wrap        = (acc >= half_period);

  // toggles at twice the pitch, averaged over time
  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (pitch == '0) begin
      sound <= 1'b0;                    // rest, acc holds its value
    end else if (wrap) begin
      acc   <= acc + step - half_period;
      sound <= ~sound;
    end else begin
      acc <= acc + step;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the music box testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert --top-module tb_music_box -f list.f > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_music_box +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "simulator exited with an error status" >> sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation gave no result, see sim.log"; exit 1; }
echo "simulation passed"

//--- sim/music_box_props.sv
// concurrent assertions on the note sequencer phase, tone pitch and part number
`timescale 1ns/1ps

module music_box_props (
  input logic                  clk,
  input logic                  rst,
  input music_box_pkg::phase_t phase,
  input music_box_pkg::pitch_t tone_pitch,
  input music_box_pkg::part_t  part
);
  import music_box_pkg::*;

  int fail_count = 0;   // failed assertion attempts so far

  load_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (!rst && phase == PH_LOAD) |=> (phase != PH_LOAD)
  ) else begin
    fail_count++;
    $error("load phase lasted longer than one cycle");
  end

  // the tone only runs while a note sounds
  pitch_silent: assert property (@(posedge clk) disable iff (rst)
    (!rst && phase != PH_SOUND) |-> (tone_pitch == '0)
  ) else begin
    fail_count++;
    $error("tone_pitch nonzero outside the sound phase");
  end

  part_range: assert property (@(posedge clk) disable iff (rst)
    !rst |-> (part >= part_t'(1) && part <= part_t'(6))
  ) else begin
    fail_count++;
    $error("part number left the range 1 to 6");
  end

endmodule

//--- sim/tb_clock_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;               // released on a rising edge
  end

endmodule

//--- sim/tb_music_box.sv
// music box testbench: stimulus, reference function, interval checker, watchdog, report
`timescale 1ns/1ps
`include "music_box_cfg.svh"

module tb_music_box;
  import music_box_pkg::*;

  localparam int TPM          = 10;   // clock cycles per ms
  localparam int CHECK_NOTES  = 4;
  localparam int CHORUS_BEATS = 46;   // beat sums of the trimmed sections
  localparam int VERSE_BEATS  = 41;
  localparam int INTRO_BEATS  = 64;
  // parts 4, 5, 6 and 1, verse at half tempo, gaps add a third
  localparam int RUN_MS = (2 * CHORUS_BEATS + 2 * VERSE_BEATS + INTRO_BEATS) * `BEAT_MS;
  localparam int WATCHDOG_CYCLES = RUN_MS * TPM * 4 / 3 + 10000;

  logic              clk;
  logic              rst;
  logic [`TPM_W-1:0] ticks_per_milli;
  logic [7:0]        led;
  logic              sound;

  // opening notes of the chorus
  pitch_t first_pitch [CHECK_NOTES] = '{10'd466, 10'd466, 10'd415, 10'd415};
  int     first_beats [CHECK_NOTES] = '{1, 1, 1, 1};
  int     part_order  [4] = '{4, 5, 6, 1};

  int   mismatch_count = 0;
  int   other_count    = 0;
  logic sample_valid   = 1'b0;
  logic cur_dot        = 1'b0;
  logic prev_dot       = 1'b0;
  logic prev_sound     = 1'b0;
  int   cur_digit      = 0;
  int   prev_digit     = 0;
  int   note_cycles    = 0;
  int   note_toggles   = 0;
  int   gap_cycles     = 0;
  int   notes_done     = 0;
  int   digit_steps    = 0;
  int   digits_seen [8];

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_gen (.clk(clk), .rst(rst));

  music_box_top DUT (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .led             (led),
    .sound           (sound)
  );

  bind note_sequencer music_box_props seq_props (
    .clk(clk), .rst(rst), .phase(phase), .tone_pitch(tone_pitch), .part(part)
  );

  // square wave toggles twice per period
  function automatic int expected_toggles(input pitch_t pitch, input int ms);
    return 2 * int'(pitch) * ms / 1000;
  endfunction

  function automatic logic [6:0] segments_for(input int digit);
    case (digit)
      0:       return 7'b0111111;
      1:       return 7'b0000110;
      2:       return 7'b1011011;
      3:       return 7'b1001111;
      4:       return 7'b1100110;
      5:       return 7'b1101101;
      6:       return 7'b1111100;   // no top bar
      7:       return 7'b0000111;
      8:       return 7'b1111111;
      9:       return 7'b1100111;
      default: return 7'b0000000;
    endcase
  endfunction

  function automatic int digit_of(input logic [6:0] segs);
    int d;
    digit_of = 15;                  // not a digit
    for (d = 0; d < 10; d++) begin
      if (segments_for(d) == segs) digit_of = d;
    end
  endfunction

  task automatic check_note(input int idx);
    int note_ms;
    int exp_val;
    note_ms = first_beats[idx] * `BEAT_MS;
    exp_val = note_ms * TPM;
    if (note_cycles != exp_val) begin
      mismatch_count++;
      $display("MISMATCH led[7] high cycles, note %0d: got 0x%0h expected 0x%0h",
               idx, note_cycles, exp_val);
    end
    exp_val = expected_toggles(first_pitch[idx], note_ms);
    if (note_toggles > exp_val + 1 || note_toggles + 1 < exp_val) begin
      mismatch_count++;
      $display("MISMATCH sound toggles, note %0d: got 0x%0h expected 0x%0h",
               idx, note_toggles, exp_val);
    end
  endtask

  task automatic check_gap(input int idx);
    int exp_val;
    exp_val = (first_beats[idx] * `BEAT_MS / 3) * TPM + 1;   // gap plus load cycle
    if (gap_cycles != exp_val) begin
      mismatch_count++;
      $display("MISMATCH led[7] low cycles after note %0d: got 0x%0h expected 0x%0h",
               idx, gap_cycles, exp_val);
    end
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = DUT.u_note_sequencer.seq_props.fail_count;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, other_count, assert_fails);
    if (mismatch_count == 0 && other_count == 0 && assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // compare process, samples between rising edges
  always @(negedge clk) begin
    if (rst) begin
      sample_valid = 1'b0;
    end else begin
      cur_dot   = led[7];
      cur_digit = digit_of(led[6:0]);
      if (!sample_valid) begin
        digits_seen[0] = cur_digit;
        digit_steps    = 1;
        gap_cycles     = 1;             // load cycle
        sample_valid   = 1'b1;
      end else begin
        if (prev_dot && (sound != prev_sound)) note_toggles++;
        if (cur_digit != prev_digit) begin
          if (cur_dot || prev_dot) begin
            other_count++;
            $display("ERROR: part display changed while the dot was lit at %0t", $time);
          end
          if (digit_steps < 8) digits_seen[digit_steps] = cur_digit;
          digit_steps++;
        end
        if (cur_dot && !prev_dot) begin
          if (notes_done > 0 && notes_done <= CHECK_NOTES) check_gap(notes_done - 1);
          note_cycles  = 1;
          note_toggles = 0;
        end else if (cur_dot) begin
          note_cycles++;
        end else if (prev_dot) begin
          if (notes_done < CHECK_NOTES) check_note(notes_done);
          notes_done++;
          gap_cycles = 1;               // last tone edge may still land here
        end else begin
          gap_cycles++;
          if (sound !== 1'b0) begin
            other_count++;
            $display("ERROR: sound active during a gap at %0t", $time);
          end
        end
      end
      prev_dot   = cur_dot;
      prev_sound = sound;
      prev_digit = cur_digit;
    end
  end

  // stimulus and end-of-run checks
  initial begin
    int i;
    ticks_per_milli = '0;
    @(posedge clk);
    ticks_per_milli <= `TPM_W'(TPM);
    @(negedge clk);
    while (rst) @(negedge clk);
    if (sound !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH sound after reset: got 0x%0h expected 0x0", sound);
    end
    if (led[7] !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH led[7] after reset: got 0x%0h expected 0x0", led[7]);
    end
    if (led[6:0] !== segments_for(part_order[0])) begin
      mismatch_count++;
      $display("MISMATCH led[6:0] after reset: got 0x%0h expected 0x%0h",
               led[6:0], segments_for(part_order[0]));
    end
    while (digit_steps < 4) @(negedge clk);
    repeat (10) @(negedge clk);
    if (notes_done < CHECK_NOTES) begin
      other_count++;
      $display("ERROR: only %0d notes were measured", notes_done);
    end
    for (i = 0; i < 4; i++) begin
      if (digits_seen[i] != part_order[i]) begin
        mismatch_count++;
        $display("MISMATCH led[6:0] digit, step %0d: got 0x%0h expected 0x%0h",
                 i, digits_seen[i], part_order[i]);
      end
    end
    finish_run();
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    other_count++;
    $display("ERROR: watchdog expired after %0d cycles before part 1 was shown",
             WATCHDOG_CYCLES);
    finish_run();
  end

endmodule
